// ==== project.f ====
+incdir+source
source/arbiter_pkg.sv
source/message_fifo.sv
source/gather_tree.sv
source/scatter_router.sv
source/final_arbitration_unit.sv
bench/tb_final_arbitration_unit.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_final_arbitration_unit
SOURCES := $(filter-out +%,$(shell cat project.f)) source/arbiter_consts.svh

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

$(SIM): project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_final_arbitration_unit -f project.f

clean:
	rm -rf obj_dir

// ==== bench/tb_final_arbitration_unit.sv ====
`default_nettype none

`include "arbiter_consts.svh"

module tb_final_arbitration_unit;

    timeunit 1ns;
    timeprecision 1ps;

    import arbiter_pkg::*;

    // about twice the cycles the six tests take
    localparam int cycle_limit = 4000;

    logic clk = 1'b0;
    logic reset = 1'b1;

    // send side, bit 8 is the stage controller
    source_words_t src_words = '0;
    source_mask_t src_valid = '0;
    source_mask_t ready_mask;
    logic final_fifo_out_ready = 1'b0;
    hub_word_t final_fifo_out_data;
    logic final_fifo_out_valid;

    // receive side
    hub_word_t final_fifo_in_data = '0;
    logic final_fifo_in_valid = 1'b0;
    logic final_fifo_in_ready;
    source_mask_t route_ready = '0;
    source_mask_t route_valid;
    hub_word_t [`MASTER_CHANNEL_COUNT-1:0] master_in_data;
    hub_word_t sc_in_data;
    logic has_flying_messages;
    logic port_valid_any;

    // knobs for drive_cycle, a rate of n bits means a chance of one in 2**n
    source_mask_t source_allow = '0;
    int source_rate = 0;
    logic drain_enable = 1'b0;
    int drain_rate = 0;
    logic recv_offer = 1'b0;
    int recv_rate = 0;
    source_mask_t dest_enable = '0;
    int dest_rate = 0;

    // scoreboards and their heads as seen after the last edge
    hub_word_t send_queue [$];
    hub_word_t recv_queue [$];
    int send_count = 0;
    int recv_count = 0;
    hub_word_t send_head = '0;
    hub_message_t recv_head = '0;
    source_mask_t send_taken = '0;
    logic in_taken = 1'b0;
    int sc_served = 0;

    logic [15:0] lfsr_state = 16'd45;
    int error_count = 0;
    int errors_before = 0;
    int tests_done = 0;
    int cycle_count = 0;

    final_arbitration_unit dut (
        .clk                 (clk),
        .reset               (reset),
        .master_out_data     (src_words[`MASTER_CHANNEL_COUNT-1:0]),
        .master_out_valid    (src_valid[`MASTER_CHANNEL_COUNT-1:0]),
        .master_out_ready    (ready_mask[`MASTER_CHANNEL_COUNT-1:0]),
        .sc_out_data         (src_words[`MASTER_CHANNEL_COUNT]),
        .sc_out_valid        (src_valid[`MASTER_CHANNEL_COUNT]),
        .sc_out_ready        (ready_mask[`MASTER_CHANNEL_COUNT]),
        .final_fifo_out_data (final_fifo_out_data),
        .final_fifo_out_valid(final_fifo_out_valid),
        .final_fifo_out_ready(final_fifo_out_ready),
        .final_fifo_in_data  (final_fifo_in_data),
        .final_fifo_in_valid (final_fifo_in_valid),
        .final_fifo_in_ready (final_fifo_in_ready),
        .master_in_data      (master_in_data),
        .master_in_valid     (route_valid[`MASTER_CHANNEL_COUNT-1:0]),
        .master_in_ready     (route_ready[`MASTER_CHANNEL_COUNT-1:0]),
        .sc_in_data          (sc_in_data),
        .sc_in_valid         (route_valid[`MASTER_CHANNEL_COUNT]),
        .sc_in_ready         (route_ready[`MASTER_CHANNEL_COUNT]),
        .has_flying_messages (has_flying_messages)
    );

    assign port_valid_any = (|src_valid) || final_fifo_out_valid ||
                            final_fifo_in_valid || (|route_valid);

    initial begin
        forever begin
            #5 clk = ~clk;
        end
    end

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    // one lfsr step per bit, zero bits gives zero
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    function automatic hub_message_t random_message();
        hub_message_t msg;
        int pick;
        msg.fpga_id = fpga_id_t'(random_bits(`FPGA_ID_WIDTH));
        // nine legal targets, the last one is the stage controller
        pick = int'(random_bits(4)) % `SOURCE_COUNT;
        if (pick == `MASTER_CHANNEL_COUNT) begin
            msg.destination = channel_index_t'(`STAGE_CONTROLLER_INDEX);
        end else begin
            msg.destination = channel_index_t'(pick);
        end
        msg.payload = payload_t'(random_bits($bits(payload_t)));
        return msg;
    endfunction

    // lowest valid index wins, none while the output FIFO is full
    function automatic source_mask_t expected_ready(input source_mask_t valid, input logic room);
        source_mask_t mask;
        int i;
        mask = '0;
        for (i = 0; i < `SOURCE_COUNT; i++) begin
            if (room && valid[i] && mask == '0) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic source_mask_t expected_route(input hub_message_t head, input logic present);
        source_mask_t mask;
        mask = '0;
        if (present && head.destination == channel_index_t'(`STAGE_CONTROLLER_INDEX)) begin
            mask[`MASTER_CHANNEL_COUNT] = 1'b1;
        end else if (present && head.destination < `MASTER_CHANNEL_COUNT) begin
            mask[int'(head.destination)] = 1'b1;
        end
        return mask;
    endfunction

    // head is broadcast to all nine outputs
    function automatic logic data_matches(input hub_word_t [`MASTER_CHANNEL_COUNT-1:0] masters,
                                          input hub_word_t sc, input hub_word_t expected);
        logic match;
        int i;
        match = (sc == expected);
        for (i = 0; i < `MASTER_CHANNEL_COUNT; i++) begin
            match = match && (masters[i] == expected);
        end
        return match;
    endfunction

    task automatic report_error(input string message);
        error_count++;
        $display("Error at %0t: %s", $time, message);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d, %s: finished with %0d errors", tests_done, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    // one falling edge, then new inputs from the knobs
    task automatic drive_cycle();
        int i;
        @(negedge clk);
        for (i = 0; i < `SOURCE_COUNT; i++) begin
            // a source keeps its word until the tree takes it
            if (!src_valid[i] || send_taken[i]) begin
                if (source_allow[i] && random_bits(source_rate) == 0) begin
                    src_valid[i] = 1'b1;
                    src_words[i] = random_bits(`HUB_WORD_WIDTH);
                end else begin
                    src_valid[i] = 1'b0;
                end
            end
        end
        final_fifo_out_ready = drain_enable && (random_bits(drain_rate) == 0);
        if (!final_fifo_in_valid || in_taken) begin
            if (recv_offer && random_bits(recv_rate) == 0) begin
                final_fifo_in_valid = 1'b1;
                final_fifo_in_data = random_message();
            end else begin
                final_fifo_in_valid = 1'b0;
            end
        end
        for (i = 0; i < `SOURCE_COUNT; i++) begin
            route_ready[i] = dest_enable[i] && (random_bits(dest_rate) == 0);
        end
    endtask

    task automatic drain_send();
        source_allow = '0;
        drain_enable = 1'b1;
        drain_rate = 0;
        while (src_valid != '0 || send_count != 0) begin
            drive_cycle();
        end
    endtask

    task automatic drain_receive();
        recv_offer = 1'b0;
        dest_enable = '1;
        dest_rate = 0;
        while (final_fifo_in_valid || recv_count != 0) begin
            drive_cycle();
        end
    endtask

    // scoreboard update, values taken before this edge's register updates
    always @(posedge clk) begin
        int i;
        if (reset) begin
            send_queue.delete();
            recv_queue.delete();
            send_taken <= '0;
            in_taken <= 1'b0;
        end else begin
            if (final_fifo_out_valid && final_fifo_out_ready && send_queue.size() != 0) begin
                void'(send_queue.pop_front());
            end
            for (i = 0; i < `SOURCE_COUNT; i++) begin
                if (src_valid[i] && ready_mask[i]) begin
                    send_queue.push_back(src_words[i]);
                end
            end
            if (src_valid[`MASTER_CHANNEL_COUNT] && ready_mask[`MASTER_CHANNEL_COUNT]) begin
                sc_served++;
            end
            if (((route_valid & route_ready) != '0) && recv_queue.size() != 0) begin
                void'(recv_queue.pop_front());
            end
            if (final_fifo_in_valid && final_fifo_in_ready) begin
                recv_queue.push_back(final_fifo_in_data);
            end
            send_taken <= src_valid & ready_mask;
            in_taken <= final_fifo_in_valid && final_fifo_in_ready;
        end
        send_count <= send_queue.size();
        send_head <= (send_queue.size() != 0) ? send_queue[0] : '0;
        recv_count <= recv_queue.size();
        recv_head <= (recv_queue.size() != 0) ? recv_queue[0] : '0;
    end

    // first edge out of reset
    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        (!final_fifo_out_valid && route_valid == '0 && !has_flying_messages && final_fifo_in_ready))
        else report_error("outputs not idle right after reset");
    a_send_priority: assert property (@(posedge clk) disable iff (reset)
        ready_mask == expected_ready(src_valid, send_count < `HUB_FIFO_DEPTH))
        else report_error("source ready not on the lowest valid source, or raised while full");
    a_out_level: assert property (@(posedge clk) disable iff (reset)
        final_fifo_out_valid == (send_count != 0))
        else report_error("output valid does not match the accepted word count");
    a_out_word: assert property (@(posedge clk) disable iff (reset)
        final_fifo_out_valid |-> final_fifo_out_data == send_head)
        else report_error("output word differs from the oldest accepted word");
    a_in_ready: assert property (@(posedge clk) disable iff (reset)
        final_fifo_in_ready == (recv_count < `HUB_FIFO_DEPTH))
        else report_error("input ready does not match the input FIFO level");
    a_route_valid: assert property (@(posedge clk) disable iff (reset)
        route_valid == expected_route(recv_head, recv_count != 0))
        else report_error("destination valid does not match the head destination");
    a_route_data: assert property (@(posedge clk) disable iff (reset)
        (recv_count != 0) |-> data_matches(master_in_data, sc_in_data, recv_head))
        else report_error("destination data differs from the oldest written word");
    // waiting head holds still
    a_route_hold: assert property (@(posedge clk) disable iff (reset)
        (route_valid != '0 && (route_valid & route_ready) == '0) |=>
        ($stable(route_valid) && $stable(sc_in_data) && $stable(master_in_data)))
        else report_error("receive head moved while its destination was not ready");
    a_flying: assert property (@(posedge clk) disable iff (reset)
        has_flying_messages == $past(port_valid_any))
        else report_error("flying flag is not the port valids one cycle late");

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("simulation timed out after %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // 1: nothing offered
        repeat (4) drive_cycle();
        finish_test("reset state");
        // 2: sparse offers from every source, output drained half the time
        source_allow = '1;
        source_rate = 3;
        drain_enable = 1'b1;
        drain_rate = 1;
        repeat (600) drive_cycle();
        // only one master left, so the stage controller gets turns
        source_allow = '0;
        source_allow[`MASTER_CHANNEL_COUNT] = 1'b1;
        source_allow[`MASTER_CHANNEL_COUNT-1] = 1'b1;
        source_rate = 2;
        repeat (150) drive_cycle();
        drain_send();
        finish_test($sformatf("priority, stage controller served %0d times", sc_served));
        // 3: all sources pushing against a stalled output
        source_allow = '1;
        source_rate = 0;
        drain_enable = 1'b0;
        while (send_count < `HUB_FIFO_DEPTH) begin
            drive_cycle();
        end
        repeat (10) drive_cycle();
        drain_send();
        finish_test("output back-pressure");
        // 4: random destinations, readies half the time
        recv_offer = 1'b1;
        recv_rate = 1;
        dest_enable = '1;
        dest_rate = 1;
        repeat (700) drive_cycle();
        drain_receive();
        finish_test("routing");
        // 5: fill the input FIFO with nobody taking
        recv_rate = 0;
        recv_offer = 1'b1;
        dest_enable = '0;
        while (recv_count < `HUB_FIFO_DEPTH) begin
            drive_cycle();
        end
        repeat (5) drive_cycle();
        // single pop by the head's own destination
        dest_enable = expected_route(recv_head, 1'b1);
        dest_rate = 0;
        drive_cycle();
        dest_enable = '0;
        repeat (5) drive_cycle();
        drain_receive();
        finish_test("input back-pressure");
        // 6: idle, one word out, idle, one word in, idle
        dest_enable = '0;
        repeat (4) drive_cycle();
        source_allow = '0;
        source_allow[2] = 1'b1;
        source_rate = 0;
        drain_enable = 1'b1;
        drain_rate = 0;
        drive_cycle();
        source_allow = '0;
        repeat (6) drive_cycle();
        recv_offer = 1'b1;
        dest_enable = '1;
        drive_cycle();
        recv_offer = 1'b0;
        repeat (6) drive_cycle();
        finish_test("flying flag");
        if (send_queue.size() != 0 || recv_queue.size() != 0) begin
            error_count++;
            $display("scoreboards still hold %0d send and %0d receive words at the end",
                     send_queue.size(), recv_queue.size());
        end
        $display("%0d tests run, %0d errors", tests_done, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/final_arbitration_unit.sv ====
`default_nettype none

`include "arbiter_consts.svh"

module final_arbitration_unit (
    input  logic                                             clk,
    input  logic                                             reset,
    input  arbiter_pkg::hub_word_t [`MASTER_CHANNEL_COUNT-1:0] master_out_data,
    input  logic [`MASTER_CHANNEL_COUNT-1:0]                 master_out_valid,
    output logic [`MASTER_CHANNEL_COUNT-1:0]                 master_out_ready,
    input  arbiter_pkg::hub_word_t                           sc_out_data,
    input  logic                                             sc_out_valid,
    output logic                                             sc_out_ready,
    output arbiter_pkg::hub_word_t                           final_fifo_out_data,
    output logic                                             final_fifo_out_valid,
    input  logic                                             final_fifo_out_ready,
    input  arbiter_pkg::hub_word_t                           final_fifo_in_data,
    input  logic                                             final_fifo_in_valid,
    output logic                                             final_fifo_in_ready,
    output arbiter_pkg::hub_word_t [`MASTER_CHANNEL_COUNT-1:0] master_in_data,
    output logic [`MASTER_CHANNEL_COUNT-1:0]                 master_in_valid,
    input  logic [`MASTER_CHANNEL_COUNT-1:0]                 master_in_ready,
    output arbiter_pkg::hub_word_t                           sc_in_data,
    output logic                                             sc_in_valid,
    input  logic                                             sc_in_ready,
    output logic                                             has_flying_messages
);

    import arbiter_pkg::*;

    // send side, nine-wide bundles with the stage controller on top
    source_words_t send_words;
    source_mask_t send_valid;
    source_mask_t send_ready;
    hub_word_t elected_word;
    logic elected_valid;
    logic out_full;
    logic out_empty;
    logic out_write;
    logic out_read;

    // receive side
    logic in_full;
    logic in_empty;
    logic in_write;
    hub_word_t in_head_word;
    hub_message_t in_head;
    source_mask_t recv_valid;
    source_mask_t recv_ready;
    source_words_t recv_data;
    logic recv_pop;

    logic flying_next;

    assign send_words = {sc_out_data, master_out_data};
    assign send_valid = {sc_out_valid, master_out_valid};
    assign master_out_ready = send_ready[`MASTER_CHANNEL_COUNT-1:0];
    assign sc_out_ready = send_ready[`MASTER_CHANNEL_COUNT];

    gather_tree tree (
        .source_data  (send_words),
        .source_valid (send_valid),
        .accept       (!out_full),
        .source_ready (send_ready),
        .elected_word (elected_word),
        .elected_valid(elected_valid)
    );

    // write exactly when the tree hands a word over
    assign out_write = elected_valid && !out_full;
    assign final_fifo_out_valid = !out_empty;
    assign out_read = final_fifo_out_ready && final_fifo_out_valid;

    // outgoing words pass through unchanged
    message_fifo #(.depth(`HUB_FIFO_DEPTH), .width(`HUB_WORD_WIDTH)) out_fifo (
        .clk       (clk),
        .reset     (reset),
        .write     (out_write),
        .write_data(elected_word),
        .full      (out_full),
        .read      (out_read),
        .read_data (final_fifo_out_data),
        .empty     (out_empty)
    );

    // ready is the free level only, independent of valid
    assign final_fifo_in_ready = !in_full;
    assign in_write = final_fifo_in_valid && final_fifo_in_ready;

    message_fifo #(.depth(`HUB_FIFO_DEPTH), .width(`HUB_WORD_WIDTH)) in_fifo (
        .clk       (clk),
        .reset     (reset),
        .write     (in_write),
        .write_data(final_fifo_in_data),
        .full      (in_full),
        .read      (recv_pop),
        .read_data (in_head_word),
        .empty     (in_empty)
    );

    // head viewed through the message fields
    assign in_head = in_head_word;
    assign recv_ready = {sc_in_ready, master_in_ready};

    scatter_router router (
        .head        (in_head),
        .head_present(!in_empty),
        .dest_ready  (recv_ready),
        .dest_valid  (recv_valid),
        .dest_data   (recv_data),
        .pop         (recv_pop)
    );

    assign master_in_valid = recv_valid[`MASTER_CHANNEL_COUNT-1:0];
    assign sc_in_valid = recv_valid[`MASTER_CHANNEL_COUNT];
    assign master_in_data = recv_data[`MASTER_CHANNEL_COUNT-1:0];
    assign sc_in_data = recv_data[`MASTER_CHANNEL_COUNT];

    // any valid seen at a port this cycle
    assign flying_next = (|send_valid) || final_fifo_out_valid ||
                         final_fifo_in_valid || (|recv_valid);

    // one cycle behind the port valids
    always_ff @(posedge clk) begin
        if (reset) begin
            has_flying_messages <= 1'b0;
        end else begin
            has_flying_messages <= flying_next;
        end
    end

    // a waiting receive head must not move until its destination takes it
    a_recv_head_held: assert property (
        @(posedge clk) disable iff (reset)
        (!in_empty && !recv_pop) |=> (!in_empty && $stable(in_head_word))
    ) else $error("receive head changed under back-pressure");

endmodule

`default_nettype wire

// ==== source/scatter_router.sv ====
`default_nettype none

`include "arbiter_consts.svh"

module scatter_router (
    input  arbiter_pkg::hub_message_t  head,
    input  logic                       head_present,
    input  arbiter_pkg::source_mask_t  dest_ready,
    output arbiter_pkg::source_mask_t  dest_valid,
    output arbiter_pkg::source_words_t dest_data,
    output logic                       pop
);

    import arbiter_pkg::*;

    logic to_master;
    logic to_stage_controller;

    // destination field split into its two legal ranges
    assign to_master = (head.destination < channel_index_t'(`MASTER_CHANNEL_COUNT));
    assign to_stage_controller =
        (head.destination == channel_index_t'(`STAGE_CONTROLLER_INDEX));

    // one valid per master channel
    for (genvar ch = 0; ch < `MASTER_CHANNEL_COUNT; ch++) begin : g_master
        assign dest_valid[ch] = head_present && (head.destination == channel_index_t'(ch));
    end

    // stage controller sits above the masters
    assign dest_valid[`MASTER_CHANNEL_COUNT] = head_present && to_stage_controller;

    // every destination sees the head, valid picks the one that takes it
    for (genvar dst = 0; dst < `SOURCE_COUNT; dst++) begin : g_data
        assign dest_data[dst] = hub_word_t'(head);
    end

    // pop on the handshake of the selected destination
    // unselected readies are masked by their valid
    assign pop = |(dest_valid & dest_ready);

    // indices 8 to 254 are outside the contract with the sending boards
    always_comb begin
        if (head_present) begin
            assert (to_master || to_stage_controller)
                else $error("scatter_router bad destination %0d", head.destination);
        end
    end

endmodule

`default_nettype wire

// ==== source/gather_tree.sv ====
`default_nettype none

`include "arbiter_consts.svh"

module gather_tree (
    input  arbiter_pkg::source_words_t source_data,
    input  arbiter_pkg::source_mask_t  source_valid,
    input  logic                       accept,
    output arbiter_pkg::source_mask_t  source_ready,
    output arbiter_pkg::hub_word_t     elected_word,
    output logic                       elected_valid
);

    import arbiter_pkg::*;

    // levels of the binary tree, 4 for nine sources
    localparam int tree_depth = $clog2(`SOURCE_COUNT);
    // sources padded up to a power of two
    localparam int leaf_count = 1 << tree_depth;
    // leaves first, then each layer, root last
    localparam int node_count = 2 * leaf_count - 1;
    localparam int root = node_count - 1;

    logic node_valid [node_count];
    hub_word_t node_word [node_count];
    logic [tree_depth-1:0] node_index [node_count];
    logic [tree_depth-1:0] elected_index;
    source_mask_t lowest_valid;

    // leaf layer
    // padding leaves never win
    for (genvar leaf = 0; leaf < leaf_count; leaf++) begin : g_leaf
        if (leaf < `SOURCE_COUNT) begin : g_source
            assign node_valid[leaf] = source_valid[leaf];
            assign node_word[leaf] = source_data[leaf];
            assign node_index[leaf] = tree_depth'(leaf);
        end else begin : g_pad
            assign node_valid[leaf] = 1'b0;
            assign node_word[leaf] = '0;
            assign node_index[leaf] = tree_depth'(leaf);
        end
    end

    // election layers, each half as wide as the one below
    for (genvar layer = 1; layer <= tree_depth; layer++) begin : g_layer
        // first node of this layer
        localparam int layer_base = 2 * leaf_count - (leaf_count >> (layer - 1));
        // first node of the layer feeding it
        localparam int child_base = 2 * leaf_count - 2 * (leaf_count >> (layer - 1));

        for (genvar slot = 0; slot < (leaf_count >> layer); slot++) begin : g_node
            localparam int left = child_base + 2 * slot;
            localparam int right = left + 1;
            localparam int node = layer_base + slot;

            assign node_valid[node] = node_valid[left] | node_valid[right];
            // left child holds the lower indices, so it wins when valid
            assign node_word[node] = node_valid[left] ? node_word[left] : node_word[right];
            assign node_index[node] = node_valid[left] ? node_index[left] : node_index[right];
        end
    end

    assign elected_valid = node_valid[root];
    assign elected_word = node_word[root];
    assign elected_index = node_index[root];

    // take strobe back to the winner only, and only when the FIFO has room
    for (genvar src = 0; src < `SOURCE_COUNT; src++) begin : g_ready
        assign source_ready[src] = accept && elected_valid &&
                                   (elected_index == tree_depth'(src));
    end

    // two's complement keeps only the lowest set bit
    assign lowest_valid = source_valid & (~source_valid + 1'b1);

    // one-hot on the lowest valid source, zero while the FIFO is full
    always_comb begin
        if (!$isunknown({source_valid, accept})) begin
            assert (source_ready == (accept ? lowest_valid : '0))
                else $error("gather_tree ready %b not on lowest valid of %b",
                            source_ready, source_valid);
        end
    end

endmodule

`default_nettype wire

// ==== source/message_fifo.sv ====
`default_nettype none

`include "arbiter_consts.svh"

module message_fifo #(
    parameter int depth = `HUB_FIFO_DEPTH,
    parameter int width = `HUB_WORD_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             write,
    input  logic [width-1:0] write_data,
    output logic             full,
    input  logic             read,
    output logic [width-1:0] read_data,
    output logic             empty
);

    // pointer width, at least one bit for a single-entry FIFO
    localparam int addr_width = (depth > 1) ? $clog2(depth) : 1;
    // occupancy must reach depth itself
    localparam int count_width = $clog2(depth + 1);

    logic [width-1:0] storage [depth];
    logic [addr_width-1:0] write_ptr;
    logic [addr_width-1:0] read_ptr;
    logic [count_width-1:0] count;
    logic do_write;
    logic do_read;

    // blocked requests are dropped here
    assign do_write = write && !full;
    assign do_read = read && !empty;

    assign full = (count == count_width'(depth));
    assign empty = (count == '0);

    // first word fall through, head shown while not empty
    assign read_data = storage[read_ptr];

    // payload storage, written only on an accepted write
    always_ff @(posedge clk) begin
        if (do_write) begin
            storage[write_ptr] <= write_data;
        end
    end

    // pointers wrap at depth, so depth need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                write_ptr <= (write_ptr == addr_width'(depth - 1)) ? '0 : write_ptr + 1'b1;
            end
            if (do_read) begin
                read_ptr <= (read_ptr == addr_width'(depth - 1)) ? '0 : read_ptr + 1'b1;
            end
            // simultaneous write and read leave count alone
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    // producer must hold off while full
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset) write |-> !full
    ) else $error("message_fifo write while full");

    // consumer must only pop a present head
    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (reset) read |-> !empty
    ) else $error("message_fifo read while empty");

endmodule

`default_nettype wire

// ==== source/arbiter_pkg.sv ====
`default_nettype none

`include "arbiter_consts.svh"

package arbiter_pkg;

    // one word as it travels through the hub
    typedef logic [`HUB_WORD_WIDTH-1:0] hub_word_t;

    // board id
    typedef logic [`FPGA_ID_WIDTH-1:0] fpga_id_t;

    // destination channel on the receiving board
    typedef logic [`CHANNEL_INDEX_WIDTH-1:0] channel_index_t;

    // whatever is left below id and destination
    typedef logic [`HUB_WORD_WIDTH-`FPGA_ID_WIDTH-`CHANNEL_INDEX_WIDTH-1:0] payload_t;

    // field layout of a hub word, msb first
    typedef struct packed {
        fpga_id_t       fpga_id;
        channel_index_t destination;
        payload_t       payload;
    } hub_message_t;

    // one bit per source or destination
    // bit 8 is the stage controller
    typedef logic [`SOURCE_COUNT-1:0] source_mask_t;

    // one word per source, same indexing as source_mask_t
    typedef hub_word_t [`SOURCE_COUNT-1:0] source_words_t;

endpackage

`default_nettype wire

// ==== source/arbiter_consts.svh ====
`ifndef ARBITER_CONSTS_SVH
`define ARBITER_CONSTS_SVH

// raw hub word, same on every port and in both FIFOs
`define HUB_WORD_WIDTH 32

// board id field at the top of a hub word
`define FPGA_ID_WIDTH 4

// destination channel field, just below the board id
`define CHANNEL_INDEX_WIDTH 8

// master channels on this board
`define MASTER_CHANNEL_COUNT 8

// masters plus the stage controller
`define SOURCE_COUNT 9

// entries in each of the two FIFOs
`define HUB_FIFO_DEPTH 16

// destination value reserved for the stage controller
// all ones of the channel field
`define STAGE_CONTROLLER_INDEX 255

`endif
